// ==== frb_pkg.sv ====
package frb_pkg;

    // one FFT channel sample, real and imaginary parts
    localparam int SAMPLE_W = 16;

    // upper bound on channels per spectrum, sizes the series sum
    localparam int MAX_CHANNELS = 256;

    // |x|^2 of two signed 16-bit parts peaks at 2^31, fits 32 unsigned
    localparam int POWER_W = 2 * SAMPLE_W;

    // headroom for MAX_CHANNELS full-scale powers
    localparam int SUM_W = POWER_W + $clog2(MAX_CHANNELS);

    typedef logic [POWER_W-1:0] power_t;
    typedef logic [SUM_W-1:0]   sum_t;

    // re in the upper half, im in the lower half
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] re;
        logic signed [SAMPLE_W-1:0] im;
    } cplx_t;

    // one beat of the dedispersed stream
    // sof on channel 0, eof on the last channel
    typedef struct packed {
        power_t data;
        logic   valid;
        logic   sof;
        logic   eof;
    } power_beat_t;

endpackage

// ==== power_detector.sv ====
`timescale 1ns/1ps

module power_detector (
    input  logic                 clk,
    input  logic                 rst,
    input  frb_pkg::cplx_t       din,
    input  logic                 din_valid,
    output frb_pkg::power_t      dout,
    output logic                 dout_valid
);

    // stage 1 squares, kept signed, always >= 0
    logic signed [2*frb_pkg::SAMPLE_W-1:0] re_sq;
    logic signed [2*frb_pkg::SAMPLE_W-1:0] im_sq;
    logic                                  sq_valid;

    // squares, full precision
    // -32768 squared is 2^30, still positive in 32 bits
    always_ff @(posedge clk) begin
        re_sq <= $signed(din.re) * $signed(din.re);
        im_sq <= $signed(din.im) * $signed(din.im);
    end

    // stage 2 sum, unsigned so 2^31 does not wrap negative
    always_ff @(posedge clk) begin
        dout <= frb_pkg::power_t'(re_sq) + frb_pkg::power_t'(im_sq);
    end

    // valid follows the data through both stages
    always_ff @(posedge clk) begin
        if (rst) begin
            sq_valid   <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            sq_valid   <= din_valid;
            dout_valid <= sq_valid;
        end
    end

endmodule

// ==== dedisp_delay_line.sv ====
`timescale 1ns/1ps

module dedisp_delay_line #(
    parameter int DELAY = 1
) (
    input  logic            clk,
    input  logic            rst,
    input  frb_pkg::power_t din,
    input  logic            din_valid,
    output frb_pkg::power_t dout,
    output logic            dout_valid
);

    // one cycle from strobe to output in every case
    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
        end
    end

    generate
        if (DELAY == 0) begin : g_no_delay
            // no delay, just the output register
            always_ff @(posedge clk) begin
                if (din_valid) begin
                    dout <= din;
                end
            end
        end else begin : g_ring
            // pointer needs at least one bit even for DELAY of 1
            localparam int PTR_W  = (DELAY > 1) ? $clog2(DELAY) : 1;
            localparam int FILL_W = $clog2(DELAY + 1);

            typedef logic [PTR_W-1:0]  ptr_t;
            typedef logic [FILL_W-1:0] fill_t;

            frb_pkg::power_t mem [DELAY];
            ptr_t            ptr;
            fill_t           fill;
            logic            full;

            // buffer has seen DELAY writes since reset
            assign full = (fill == fill_t'(DELAY));

            // pointer and fill count, control state
            always_ff @(posedge clk) begin
                if (rst) begin
                    ptr  <= '0;
                    fill <= '0;
                end else if (din_valid) begin
                    ptr <= (ptr == ptr_t'(DELAY - 1)) ? '0 : ptr + 1'b1;
                    // saturates once full
                    if (!full) begin
                        fill <= fill + 1'b1;
                    end
                end
            end

            // read-before-write at the same slot
            // slot holds the word from DELAY strobes ago
            always_ff @(posedge clk) begin
                if (din_valid) begin
                    mem[ptr] <= din;
                    dout     <= full ? mem[ptr] : '0;
                end
            end
        end
    endgenerate

endmodule

// ==== dedispersor.sv ====
`timescale 1ns/1ps

module dedispersor #(
    parameter int                      N_CHANNELS  = 8,
    // channel 0 in the low word, delays in spectra
    parameter logic [32*N_CHANNELS-1:0] DELAY_ARRAY = {
        32'd9, 32'd8, 32'd7, 32'd6, 32'd5, 32'd4, 32'd3, 32'd2
    }
) (
    input  logic                 clk,
    input  logic                 rst,
    input  frb_pkg::power_t      din,
    input  logic                 din_valid,
    output frb_pkg::power_beat_t dout
);

    localparam int CH_W = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

    // input reg, delay line, output reg, select
    localparam int PIPE_DEPTH = 4;

    typedef logic [CH_W-1:0] chan_t;

    chan_t                 ch_cnt;
    logic [N_CHANNELS-1:0] in_strobe;
    frb_pkg::power_t       in_data;

    frb_pkg::power_t       line_data [N_CHANNELS];
    logic [N_CHANNELS-1:0] line_valid;

    frb_pkg::power_t       out_data [N_CHANNELS];
    logic [N_CHANNELS-1:0] out_valid;

    frb_pkg::power_t       sel_data;
    logic                  sel_valid;

    logic [PIPE_DEPTH-1:0] sof_sr;
    logic [PIPE_DEPTH-1:0] eof_sr;

    // channel of the incoming sample
    always_ff @(posedge clk) begin
        if (rst) begin
            ch_cnt <= '0;
        end else if (din_valid) begin
            ch_cnt <= (ch_cnt == chan_t'(N_CHANNELS - 1)) ? '0 : ch_cnt + 1'b1;
        end
    end

    // one-hot strobe, only the current channel's line sees it
    always_ff @(posedge clk) begin
        if (rst) begin
            in_strobe <= '0;
        end else begin
            in_strobe <= din_valid ? (N_CHANNELS'(1) << ch_cnt) : '0;
        end
    end

    // data fans out to every line
    always_ff @(posedge clk) begin
        in_data <= din;
    end

    generate
        for (genvar i = 0; i < N_CHANNELS; i++) begin : g_chan
            dedisp_delay_line #(
                .DELAY(int'(DELAY_ARRAY[32*i +: 32]))
            ) u_line (
                .clk       (clk),
                .rst       (rst),
                .din       (in_data),
                .din_valid (in_strobe[i]),
                .dout      (line_data[i]),
                .dout_valid(line_valid[i])
            );

            // register each line output before the wide select
            always_ff @(posedge clk) begin
                out_data[i] <= line_data[i];
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    out_valid[i] <= 1'b0;
                end else begin
                    out_valid[i] <= line_valid[i];
                end
            end
        end
    endgenerate

    // at most one channel active per cycle
    // data holds when none is
    always_ff @(posedge clk) begin
        for (int c = 0; c < N_CHANNELS; c++) begin
            if (out_valid[c]) begin
                sel_data <= out_data[c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_valid <= 1'b0;
        end else begin
            sel_valid <= |out_valid;
        end
    end

    // frame marks from the input counter
    // shifted every cycle, same depth as the data path
    always_ff @(posedge clk) begin
        if (rst) begin
            sof_sr <= '0;
            eof_sr <= '0;
        end else begin
            sof_sr <= {sof_sr[PIPE_DEPTH-2:0], din_valid && (ch_cnt == '0)};
            eof_sr <= {eof_sr[PIPE_DEPTH-2:0],
                       din_valid && (ch_cnt == chan_t'(N_CHANNELS - 1))};
        end
    end

    assign dout = '{
        data:  sel_data,
        valid: sel_valid,
        sof:   sof_sr[PIPE_DEPTH-1],
        eof:   eof_sr[PIPE_DEPTH-1]
    };

endmodule

// ==== frame_summer.sv ====
`timescale 1ns/1ps

module frame_summer (
    input  logic                 clk,
    input  logic                 rst,
    input  frb_pkg::power_beat_t beat,
    output frb_pkg::sum_t        sum,
    output logic                 sum_valid
);

    frb_pkg::sum_t acc;
    frb_pkg::sum_t acc_next;

    // sof restarts the total, handles a one-channel frame too
    assign acc_next = beat.sof ? frb_pkg::sum_t'(beat.data)
                               : acc + frb_pkg::sum_t'(beat.data);

    // running total over the frame
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (beat.valid) begin
            acc <= acc_next;
        end
    end

    // final total on the eof beat
    always_ff @(posedge clk) begin
        if (beat.valid && beat.eof) begin
            sum <= acc_next;
        end
    end

    // one pulse per frame
    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= beat.valid && beat.eof;
        end
    end

endmodule

// ==== frb_dedisp_top.sv ====
`timescale 1ns/1ps

module frb_dedisp_top #(
    parameter int                      N_CHANNELS  = 8,
    // channel 0 in the low word
    parameter logic [32*N_CHANNELS-1:0] DELAY_ARRAY = {
        32'd9, 32'd8, 32'd7, 32'd6, 32'd5, 32'd4, 32'd3, 32'd2
    }
) (
    input  logic            clk,
    input  logic            rst,
    input  frb_pkg::cplx_t  in_sample,
    input  logic            in_valid,
    output frb_pkg::power_t spec_power,
    output logic            spec_valid,
    output logic            spec_sof,
    output logic            spec_eof,
    output frb_pkg::sum_t   series_sum,
    output logic            series_valid
);

    frb_pkg::power_t      det_power;
    logic                 det_valid;
    frb_pkg::power_beat_t dd_beat;

    // complex sample to power, 2 cycles
    power_detector u_power_detector (
        .clk       (clk),
        .rst       (rst),
        .din       (in_sample),
        .din_valid (in_valid),
        .dout      (det_power),
        .dout_valid(det_valid)
    );

    // per-channel delay, 4 cycles
    dedispersor #(
        .N_CHANNELS (N_CHANNELS),
        .DELAY_ARRAY(DELAY_ARRAY)
    ) u_dedispersor (
        .clk      (clk),
        .rst      (rst),
        .din      (det_power),
        .din_valid(det_valid),
        .dout     (dd_beat)
    );

    // band sum per aligned frame, 1 cycle after eof
    frame_summer u_frame_summer (
        .clk      (clk),
        .rst      (rst),
        .beat     (dd_beat),
        .sum      (series_sum),
        .sum_valid(series_valid)
    );

    // dedispersed stream out to the ports
    assign spec_power = dd_beat.data;
    assign spec_valid = dd_beat.valid;
    assign spec_sof   = dd_beat.sof;
    assign spec_eof   = dd_beat.eof;

endmodule

// ==== tb_frb_dedisp_top.sv ====
`timescale 1ns/1ps

module tb_frb_dedisp_top;

    localparam int  N_CHANNELS   = 8;
    localparam time CLK_PERIOD   = 100ns;
    localparam int  RESET_CYCLES = 16;
    // enough zero frames to drain the deepest delay line
    localparam int  FLUSH_FRAMES = 9;
    localparam int  BEAT_LAT     = 6;
    localparam int  SUM_LAT      = 7;
    // delays in spectra with channel 0 first
    localparam int  DELAYS [N_CHANNELS] = '{2, 3, 4, 5, 6, 7, 8, 9};

    typedef struct packed {
        int re;
        int im;
        int gap;
    } stim_t;

    typedef struct packed {
        frb_pkg::power_t power;
        logic            sof;
        logic            eof;
        int              cyc;
    } exp_beat_t;

    typedef struct packed {
        frb_pkg::sum_t sum;
        int            cyc;
    } exp_sum_t;

    logic            clk;
    logic            rst;
    frb_pkg::cplx_t  in_sample;
    logic            in_valid;
    frb_pkg::power_t spec_power;
    logic            spec_valid;
    logic            spec_sof;
    logic            spec_eof;
    frb_pkg::sum_t   series_sum;
    logic            series_valid;

    stim_t           stim_q [$];
    frb_pkg::power_t power_hist [$];
    exp_beat_t       exp_beat_q [$];
    exp_sum_t        exp_sum_q [$];
    frb_pkg::sum_t   frame_acc;
    logic [15:0]     lfsr_state;
    logic            stim_loaded;
    int              total_cycles;
    int              cyc;

    frb_dedisp_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .in_sample   (in_sample),
        .in_valid    (in_valid),
        .spec_power  (spec_power),
        .spec_valid  (spec_valid),
        .spec_sof    (spec_sof),
        .spec_eof    (spec_eof),
        .series_sum  (series_sum),
        .series_valid(series_valid)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // cycle count read after the edge by stimulus and at negedge by the monitor
    initial cyc = 0;
    always @(posedge clk) cyc <= cyc + 1;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("FAILED at %0t: %s is %0d, expected %0d",
                               $time, what, got, expected));
        end
    endtask

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // 3 random bits with one lfsr step per bit
    task automatic draw_gap(output int gap);
        gap = 0;
        for (int b = 0; b < 3; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            gap = (gap << 1) | int'(lfsr_state[0]);
        end
    endtask

    // detected power as re^2 + im^2
    function automatic frb_pkg::power_t sample_power(input int re, input int im);
        longint p;
        p = longint'(re) * longint'(re) + longint'(im) * longint'(im);
        return frb_pkg::power_t'(p);
    endfunction

    task automatic load_stimulus();
        int    fd;
        int    n;
        stim_t s;
        string line;
        fd = $fopen("tb_input_frames.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the stimulus file tb_input_frames.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // comment and blank lines
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d", s.re, s.im, s.gap);
            if (n == 3) begin
                if (s.gap < 0) begin
                    draw_gap(s.gap);
                end
                stim_q.push_back(s);
            end
        end
        $fclose(fd);
        if (stim_q.size() % N_CHANNELS != 0) begin
            fail_run("stimulus file does not hold whole frames");
        end
        // zero frames push the last pulses out of the delay lines
        repeat (FLUSH_FRAMES * N_CHANNELS) begin
            stim_q.push_back('{re: 0, im: 0, gap: 0});
        end
        total_cycles = 0;
        foreach (stim_q[i]) begin
            total_cycles += 1 + stim_q[i].gap;
        end
    endtask

    // drive one sample and queue what the dedispersed stream must show for it
    task automatic drive_sample(input stim_t s);
        int              n;
        int              c;
        int              f;
        frb_pkg::power_t expected;
        @(posedge clk);
        #1;
        in_sample.re = s.re[frb_pkg::SAMPLE_W-1:0];
        in_sample.im = s.im[frb_pkg::SAMPLE_W-1:0];
        in_valid     = 1'b1;
        n = power_hist.size();
        c = n % N_CHANNELS;
        f = n / N_CHANNELS;
        power_hist.push_back(sample_power(s.re, s.im));
        // channel c shows its own power from DELAYS[c] frames back
        expected = (f >= DELAYS[c]) ? power_hist[n - DELAYS[c] * N_CHANNELS] : '0;
        frame_acc = (c == 0) ? frb_pkg::sum_t'(expected)
                             : frame_acc + frb_pkg::sum_t'(expected);
        exp_beat_q.push_back('{power: expected, sof: (c == 0),
                               eof: (c == N_CHANNELS - 1), cyc: cyc});
        if (c == N_CHANNELS - 1) begin
            exp_sum_q.push_back('{sum: frame_acc, cyc: cyc});
        end
        repeat (s.gap) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    // outputs change on posedge and are sampled at negedge
    always @(negedge clk) begin
        exp_beat_t eb;
        exp_sum_t  es;
        if (!rst && spec_valid) begin
            if (exp_beat_q.size() == 0) begin
                fail_run("spec_valid beat arrived with no input sample left to match");
            end else begin
                eb = exp_beat_q.pop_front();
                compare_value("spec_power", spec_power, eb.power);
                compare_value("spec_sof", spec_sof, eb.sof);
                compare_value("spec_eof", spec_eof, eb.eof);
                compare_value("in_valid to spec_valid cycles", cyc - eb.cyc, BEAT_LAT);
            end
        end else if (!rst) begin
            // marks only ride on valid beats
            compare_value("spec_sof without spec_valid", spec_sof, 1'b0);
            compare_value("spec_eof without spec_valid", spec_eof, 1'b0);
        end
        if (!rst && series_valid) begin
            if (exp_sum_q.size() == 0) begin
                fail_run("series_valid pulse arrived with no frame left to match");
            end else begin
                es = exp_sum_q.pop_front();
                compare_value("series_sum", series_sum, es.sum);
                compare_value("last in_valid to series_valid cycles", cyc - es.cyc, SUM_LAT);
            end
        end
    end

    initial begin : watchdog
        wait (stim_loaded);
        #(CLK_PERIOD * 10 * (total_cycles + 50));
        fail_run("timeout, DUT outputs stopped before all expected beats and sums arrived");
    end

    initial begin : main
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_sample   = '0;
        frame_acc   = '0;
        stim_loaded = 1'b0;
        lfsr_state  = 16'd4;
        load_stimulus();
        stim_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (stim_q[i]) begin
            drive_sample(stim_q[i]);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (exp_beat_q.size() != 0 || exp_sum_q.size() != 0) begin
            @(posedge clk);
        end
        // room for any stray beat to show up
        repeat (20) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== tb_input_frames.txt ====
# columns: re im gap, signed decimal, one channel sample per line, channel 0 first
# gap is idle cycles after the sample, -1 takes a random gap of 0 to 7 cycles
-32768 -32768 0
-32768 -32768 0
-32768 -32768 0
-32768 -32768 0
-32768 -32768 0
-32768 -32768 0
-32768 -32768 0
-32768 -32768 0
1 2 0
-3 4 0
0 0 0
5 -5 0
7 1 0
-2 -9 0
32767 32767 0
10 0 0
0 1 0
12 -6 0
-1 -1 0
100 -100 0
4 4 0
-32768 0 0
8 -3 0
0 -7 0
6 6 0
-20 15 0
3 0 0
0 2 0
0 -32768 0
9 9 0
-11 5 0
1 -1 0
-5 3 -1
2 2 -1
300 -400 -1
32767 -32768 -1
-7 0 -1
1 1 -1
0 9 -1
-4 -4 -1
13 0 3
-1 8 -1
-32768 32767 0
2 -2 -1
0 0 5
-6 -6 -1
15 1 0
3 3 -1
7 -7 -1
30000 -30000 -1
-3 -3 -1
1 0 -1
25 -25 -1
0 -1 -1
4 0 -1
-9 2 -1
-32768 -32768 -1
2 5 0
-8 1 -1
11 -11 2
0 3 -1
-1 -2 0
6 -6 -1
5 5 -1

// ==== frb_dedisp_top.f ====
frb_pkg.sv
power_detector.sv
dedisp_delay_line.sv
dedispersor.sv
frame_summer.sv
frb_dedisp_top.sv
tb_frb_dedisp_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the dedispersion testbench
# exit status is 0 only when the simulation log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing \
    --top-module tb_frb_dedisp_top \
    -f frb_dedisp_top.f \
    -o tb_frb_dedisp_top \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_frb_dedisp_top > sim.log 2>&1
cat sim.log

grep -qx "TESTBENCH PASSED" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
